/* logic/core_pkg.sv */
package core_pkg;

    parameter int xlen      = 32;
    parameter int reg_count = 32;

    typedef logic [xlen-1:0] word_t;                  // datapath word
    typedef logic [$clog2(reg_count)-1:0] reg_addr_t;  // x0..x31

    // alu_pass_b forwards operand b for lui
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,  // signed
        br_ge   // signed
    } branch_t;

endpackage

/* logic/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  core_pkg::word_t   pc,
    input  core_pkg::word_t   rs1_data,
    input  core_pkg::word_t   rs2_data,
    input  core_pkg::word_t   imm,
    input  core_pkg::alu_op_t alu_op,
    input  logic              use_imm,
    input  core_pkg::branch_t branch,
    input  logic              is_jal,
    output core_pkg::word_t   wb_data,
    output logic              take_jump
);
    import core_pkg::*;

    localparam int shamt_w = $clog2(xlen);

    word_t              op_b;
    word_t              alu_y;
    logic [shamt_w-1:0] shamt;
    logic               br_taken;

    assign op_b  = use_imm ? imm : rs2_data;
    assign shamt = op_b[shamt_w-1:0];  // low five bits only

    always_comb begin
        case (alu_op)
            alu_add:    alu_y = rs1_data + op_b;
            alu_sub:    alu_y = rs1_data - op_b;
            alu_sll:    alu_y = rs1_data << shamt;
            alu_srl:    alu_y = rs1_data >> shamt;
            alu_sra:    alu_y = $signed(rs1_data) >>> shamt;
            alu_and:    alu_y = rs1_data & op_b;
            alu_or:     alu_y = rs1_data | op_b;
            alu_xor:    alu_y = rs1_data ^ op_b;
            alu_pass_b: alu_y = op_b;
            default:    alu_y = '0;
        endcase
    end

    // signed compare on the register operands
    always_comb begin
        case (branch)
            br_eq:   br_taken = (rs1_data == rs2_data);
            br_ne:   br_taken = (rs1_data != rs2_data);
            br_lt:   br_taken = ($signed(rs1_data) < $signed(rs2_data));
            br_ge:   br_taken = ($signed(rs1_data) >= $signed(rs2_data));
            default: br_taken = 1'b0;
        endcase
    end

    assign take_jump = is_jal | br_taken;

    // link address for jal
    assign wb_data = is_jal ? (pc + word_t'(4)) : alu_y;

endmodule

/* logic/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  core_pkg::word_t     instr,
    output core_pkg::reg_addr_t rs1,
    output core_pkg::reg_addr_t rs2,
    output core_pkg::reg_addr_t rd,
    output core_pkg::word_t     imm,
    output core_pkg::alu_op_t   alu_op,
    output logic                use_imm,
    output core_pkg::branch_t   branch,
    output logic                is_jal,
    output logic                reg_write
);
    import core_pkg::*;
    import isa_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = instr[opcode_lsb +: 7];
    assign funct3 = instr[funct3_lsb +: 3];
    assign funct7 = instr[funct7_lsb +: 7];

    assign rd  = instr[rd_lsb +: 5];
    assign rs1 = instr[rs1_lsb +: 5];
    assign rs2 = instr[rs2_lsb +: 5];

    // immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'd0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        alu_op    = alu_add;
        use_imm   = 1'b0;
        branch    = br_none;
        is_jal    = 1'b0;
        reg_write = 1'b0;
        imm       = imm_i;

        case (opcode)
            op_reg: begin
                reg_write = 1'b1;
                case (funct3)
                    f3_add_sub: alu_op = (funct7 == f7_alt) ? alu_sub : alu_add;
                    f3_sll:     alu_op = alu_sll;
                    f3_xor:     alu_op = alu_xor;
                    f3_srl_sra: alu_op = (funct7 == f7_alt) ? alu_sra : alu_srl;
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                    default:    reg_write = 1'b0;  // slt/sltu not supported
                endcase
            end

            op_imm: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                case (funct3)
                    f3_add_sub: alu_op = alu_add;
                    f3_sll:     alu_op = alu_sll;
                    f3_xor:     alu_op = alu_xor;
                    f3_srl_sra: alu_op = (funct7 == f7_alt) ? alu_sra : alu_srl;
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                    default:    reg_write = 1'b0;
                endcase
            end

            op_lui: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_op    = alu_pass_b;
                imm       = imm_u;
            end

            op_branch: begin
                imm = imm_b;
                case (funct3)
                    f3_beq:  branch = br_eq;
                    f3_bne:  branch = br_ne;
                    f3_blt:  branch = br_lt;
                    f3_bge:  branch = br_ge;
                    default: branch = br_none;  // unsigned forms fall through
                endcase
            end

            op_jal: begin
                reg_write = 1'b1;
                is_jal    = 1'b1;
                imm       = imm_j;
            end

            // anything else runs as a nop
            default: begin
                reg_write = 1'b0;
            end
        endcase
    end

endmodule

/* logic/isa_pkg.sv */
package isa_pkg;

    typedef logic [6:0] opcode_t;

    // major opcodes
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jal    = 7'b1101111;

    // funct3 for alu ops
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 for branches
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    localparam logic [6:0] f7_alt = 7'b0100000;  // sub, sra, srai

    // low bit of each instruction field
    localparam int opcode_lsb = 0;
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

    localparam logic [31:0] nop_inst = 32'h0000_0013;  // addi x0,x0,0

endpackage

/* logic/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            take_jump,
    input  core_pkg::word_t imm,
    output core_pkg::word_t pc
);
    import core_pkg::*;

    word_t pc_seq;
    word_t pc_target;
    word_t pc_next;

    assign pc_seq    = pc + word_t'(4);
    assign pc_target = pc + imm;  // branch or jal offset
    assign pc_next   = take_jump ? pc_target : pc_seq;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  core_pkg::reg_addr_t rd,
    input  logic                we,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data
);
    import core_pkg::*;

    word_t [reg_count-1:0] regs;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regs <= '0;
        end else if (we && rd != '0) begin  // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    // reads see the old value during a write
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::word_t     instr,
    output core_pkg::word_t     pc,
    output logic                wb_en,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data
);
    import core_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    alu_op_t   alu_op;
    logic      use_imm;
    branch_t   branch;
    logic      is_jal;
    logic      reg_write;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      take_jump;

    inst_decoder u_decoder (
        .instr     (instr),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .branch    (branch),
        .is_jal    (is_jal),
        .reg_write (reg_write)
    );

    register_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .we       (reg_write),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit u_exec (
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .branch    (branch),
        .is_jal    (is_jal),
        .wb_data   (wb_data),
        .take_jump (take_jump)
    );

    pc_unit #(
        .reset_pc (reset_pc)
    ) u_pc (
        .clk       (clk),
        .rst       (rst),
        .take_jump (take_jump),
        .imm       (imm),
        .pc        (pc)
    );

    // writeback strobe is high even for rd = x0
    assign wb_en = reg_write;
    assign wb_rd = rd;

endmodule

/* run_sim.sh */
#!/bin/sh
# build the rv_core testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module rv_core_tb -f rv_core.f -o vsim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/vsim > sim.log 2>&1
grep -q "RESULT: PASS" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* rv_core.f */
logic/core_pkg.sv
logic/isa_pkg.sv
logic/inst_decoder.sv
logic/register_file.sv
logic/exec_unit.sv
logic/pc_unit.sv
logic/rv_core.sv
sim/rv_core_tb.sv

/* sim/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;
    import core_pkg::*;
    import isa_pkg::*;

    localparam word_t reset_pc   = 32'h0000_0100;
    localparam int    clk_period = 20;
    localparam int    r_rounds   = 4;
    // reset cycles plus one step per instruction of each test
    localparam int    step_count = 8 + 8 + r_rounds * 12 + 15 + 18 + 4 + 8;
    localparam int    timeout_ns = (step_count + 20) * clk_period;

    logic      clk;
    logic      rst;
    word_t     instr;
    word_t     pc;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    word_t     s_pc;  // outputs captured just before the edge
    logic      s_wb_en;
    reg_addr_t s_wb_rd;
    word_t     s_wb_data;

    word_t     model [reg_count];  // expected register contents
    word_t     exp_pc;

    rv_core #(
        .reset_pc (reset_pc)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm12, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd);
        return {imm12, rs1, f3, rd, op_imm};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm20, input reg_addr_t rd);
        return {imm20, rd, op_lui};
    endfunction

    function automatic word_t b_type(input int off, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], op_branch};
    endfunction

    function automatic word_t j_type(input int off, input reg_addr_t rd);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], rd, op_jal};
    endfunction

    // rv32i semantics of the kept alu instructions
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        logic [4:0] sh;
        word_t      r;
        sh = b[4:0];
        case (f3)
            f3_add_sub: r = alt ? a - b : a + b;
            f3_sll:     r = a << sh;
            f3_xor:     r = a ^ b;
            f3_srl_sra: begin
                if (alt) begin
                    r = $signed(a) >>> sh;
                end else begin
                    r = a >> sh;
                end
            end
            f3_or:      r = a | b;
            default:    r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            f3_beq:  return a == b;
            f3_bne:  return a != b;
            f3_blt:  return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic step_inst(input word_t inst);
        instr = inst;
        #(clk_period - 3);  // 1 ns before the next edge
        s_pc      = pc;
        s_wb_en   = wb_en;
        s_wb_rd   = wb_rd;
        s_wb_data = wb_data;
        @(posedge clk);
        #2;
    endtask

    // writing instruction that moves pc on by 4
    task automatic write_step(input word_t inst, input reg_addr_t rd, input word_t exp);
        step_inst(inst);
        check_word("pc", s_pc, exp_pc);
        check_bit("wb_en", s_wb_en, 1'b1);
        check_addr("wb_rd", s_wb_rd, rd);
        check_word("wb_data", s_wb_data, exp);
        if (rd != '0) model[rd] = exp;
        exp_pc = exp_pc + 4;
    endtask

    task automatic quiet_step(input word_t inst, input word_t next_pc);
        step_inst(inst);
        check_word("pc", s_pc, exp_pc);
        check_bit("wb_en", s_wb_en, 1'b0);
        exp_pc = next_pc;
    endtask

    task automatic reg_op(input logic [2:0] f3, input logic alt, input reg_addr_t rs1,
                          input reg_addr_t rs2, input reg_addr_t rd);
        word_t exp;
        exp = alu_ref(f3, alt, model[rs1], model[rs2]);
        write_step(r_type(alt ? f7_alt : 7'd0, rs2, rs1, f3, rd), rd, exp);
    endtask

    task automatic imm_op(input logic [2:0] f3, input logic [11:0] imm12,
                          input reg_addr_t rs1, input reg_addr_t rd);
        logic  alt;
        logic  is_shift;
        word_t b;
        is_shift = (f3 == f3_sll) || (f3 == f3_srl_sra);
        alt      = (f3 == f3_srl_sra) && (imm12[11:5] == f7_alt);
        b        = is_shift ? {27'd0, imm12[4:0]} : sext12(imm12);
        write_step(i_type(imm12, rs1, f3, rd), rd, alu_ref(f3, alt, model[rs1], b));
    endtask

    // lui then addi with the upper part rounded for the sign of the low part
    task automatic load_reg(input reg_addr_t rd, input word_t value);
        logic [19:0] hi;
        logic [11:0] lo;
        word_t       upper;
        lo    = value[11:0];
        hi    = value[31:12] + {19'd0, value[11]};
        upper = {hi, 12'd0};
        write_step(u_type(hi, rd), rd, upper);
        write_step(i_type(lo, rd, f3_add_sub, rd), rd, upper + sext12(lo));
    endtask

    task automatic branch_op(input logic [2:0] f3, input reg_addr_t rs1,
                             input reg_addr_t rs2, input int off);
        word_t target;
        if (branch_ref(f3, model[rs1], model[rs2])) target = exp_pc + word_t'(off);
        else target = exp_pc + 4;
        quiet_step(b_type(off, rs2, rs1, f3), target);
    endtask

    task automatic branch_trio(input logic [2:0] f3);
        branch_op(f3, 5'd1, 5'd3, 16);   // equal
        branch_op(f3, 5'd1, 5'd2, -12);  // smaller signed but larger unsigned
        branch_op(f3, 5'd2, 5'd1, 24);   // larger
    endtask

    task automatic jal_op(input reg_addr_t rd, input int off);
        word_t target;
        target = exp_pc + word_t'(off);
        write_step(j_type(off, rd), rd, exp_pc + 4);
        exp_pc = target;
    endtask

    task automatic nop_after_reset();
        exp_pc = reset_pc;
        repeat (4) write_step(nop_inst, '0, '0);
        imm_op(f3_add_sub, 12'h000, 5'd15, 5'd14);  // cleared register
        imm_op(f3_add_sub, 12'h07b, '0, '0);        // dropped by x0
        imm_op(f3_add_sub, 12'h007, '0, 5'd5);
        reg_op(f3_add_sub, 1'b0, '0, 5'd5, 5'd6);
    endtask

    task automatic register_ops();
        word_t a;
        word_t b;
        for (int n = 0; n < r_rounds; n++) begin
            a = $urandom();
            b = $urandom();
            if (n % 2 == 0) a[31] = 1'b1;  // negative for sra
            load_reg(5'd1, a);
            load_reg(5'd2, b);
            reg_op(f3_add_sub, 1'b0, 5'd1, 5'd2, 5'd3);
            reg_op(f3_add_sub, 1'b1, 5'd1, 5'd2, 5'd4);
            reg_op(f3_sll, 1'b0, 5'd1, 5'd2, 5'd5);
            reg_op(f3_srl_sra, 1'b0, 5'd1, 5'd2, 5'd6);
            reg_op(f3_srl_sra, 1'b1, 5'd1, 5'd2, 5'd7);
            reg_op(f3_and, 1'b0, 5'd1, 5'd2, 5'd8);
            reg_op(f3_or, 1'b0, 5'd1, 5'd2, 5'd9);
            reg_op(f3_xor, 1'b0, 5'd1, 5'd2, 5'd10);
        end
    endtask

    task automatic immediate_ops();
        load_reg(5'd1, 32'h8765_4321);
        load_reg(5'd2, 32'h1234_5678);
        imm_op(f3_add_sub, 12'hffb, 5'd1, 5'd3);  // -5
        imm_op(f3_add_sub, 12'h7ff, 5'd2, 5'd4);
        imm_op(f3_and, 12'h800, 5'd1, 5'd5);
        imm_op(f3_or, 12'hf0f, 5'd2, 5'd6);
        imm_op(f3_xor, 12'hfff, 5'd2, 5'd7);
        imm_op(f3_sll, 12'h007, 5'd1, 5'd8);
        imm_op(f3_srl_sra, 12'h009, 5'd1, 5'd9);
        imm_op(f3_srl_sra, {f7_alt, 5'd9}, 5'd1, 5'd10);
        imm_op(f3_srl_sra, {f7_alt, 5'd4}, 5'd2, 5'd11);
        write_step(u_type(20'hfedcb, 5'd12), 5'd12, 32'hfedc_b000);
        write_step(u_type(20'h00001, 5'd13), 5'd13, 32'h0000_1000);
    endtask

    task automatic signed_branches();
        load_reg(5'd1, 32'hffff_fffd);  // -3
        load_reg(5'd2, 32'd5);
        load_reg(5'd3, 32'hffff_fffd);
        branch_trio(f3_beq);
        branch_trio(f3_bne);
        branch_trio(f3_blt);
        branch_trio(f3_bge);
    endtask

    task automatic jump_and_link();
        jal_op(5'd9, 24);
        jal_op(5'd10, -36);  // backward
        jal_op('0, 8);
        imm_op(f3_add_sub, 12'h000, 5'd9, 5'd11);
    endtask

    task automatic unknown_opcodes();
        opcode_t odd [6];
        odd = '{7'b0000011, 7'b0100011, 7'b0010111, 7'b1100111, 7'b1110011, 7'b1111111};
        foreach (odd[k]) quiet_step({12'h7ff, 5'd2, 3'b010, 5'd1, odd[k]}, exp_pc + 4);
        imm_op(f3_add_sub, 12'h000, 5'd1, 5'd12);
        imm_op(f3_add_sub, 12'h000, 5'd2, 5'd13);
    endtask

    initial begin
        #(timeout_ns);
        $display("the run timed out after %0d ns before the tests finished", $time);
        abort_run();
    end

    initial begin
        void'($urandom(32'hc0fda6d3));
        rst   = 1'b0;
        instr = nop_inst;
        for (int i = 0; i < reg_count; i++) model[i] = '0;
        repeat (8) @(posedge clk);
        #2;
        check_word("pc during reset", pc, reset_pc);
        rst = 1'b1;
        nop_after_reset();
        register_ops();
        immediate_ops();
        signed_branches();
        jump_and_link();
        unknown_opcodes();
        $display("RESULT: PASS");
        $finish;
    end

endmodule
